// ==== dma_settings.svh ====
/*
 * Global sizes of the DMA write termination subsystem.
 * Included by the packages and by every module that sizes a port or a FIFO.
 */

`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

// Bytes per bus word, also the number of byte lanes
`define DMA_STRB_W 4

// Byte address width on the transfer and port side
`define DMA_ADDR_W 16

// Transfer id width
`define DMA_ID_W 3

// Transfer length width in bytes
`define DMA_LEN_W 8

// Entries per lane FIFO and in the last-flag FIFO
`define DMA_BUF_DEPTH 4

`endif

// ==== dma_xfer_pkg.sv ====
/*
 * Transfer-side types: requests from the host, aligned beats from the
 * legalizer and per-beat completions back to the host.
 */

`include "dma_settings.svh"

package dma_xfer_pkg;

    // Basic fields
    typedef logic [`DMA_ADDR_W-1:0] addr_t;
    typedef logic [`DMA_LEN_W-1:0] len_t;
    typedef logic [`DMA_ID_W-1:0] id_t;
    // Byte lane index inside one bus word
    typedef logic [$clog2(`DMA_STRB_W)-1:0] offs_t;

    // One transfer request
    typedef struct packed {
        addr_t dst_addr;
        len_t  length;
        id_t   id;
    } xfer_req_t;

    // One word-aligned beat
    typedef struct packed {
        // Word address, byte address without the lane bits
        addr_t addr;
        id_t   id;
        // First valid lane
        offs_t offset;
        // Lane after the last valid one, zero means up to the word end
        offs_t tailer;
        logic  last;
    } beat_t;

    // Completion of one beat
    typedef struct packed {
        id_t  id;
        logic err;
        logic last;
    } done_t;

    // Legalizer FSM
    typedef enum logic {
        IDLE,
        BUSY
    } legal_state_e;

endpackage

// ==== dma_bus_pkg.sv ====
/*
 * Termination-port types: bytes, words and strobes of the bus, plus the
 * request and response channel bundles of the simple write port.
 */

`include "dma_settings.svh"

package dma_bus_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [`DMA_STRB_W*8-1:0] data_t;
    typedef logic [`DMA_STRB_W-1:0] strb_t;

    // Write channel payload
    typedef struct packed {
        logic [`DMA_ADDR_W-1:0] addr;
        logic [`DMA_ID_W-1:0]   id;
        data_t                  data;
        strb_t                  strb;
    } term_chan_t;

    // Manager to target
    typedef struct packed {
        logic       req_valid;
        term_chan_t req_chan;
        logic       rsp_ready;
    } term_req_t;

    // Target to manager, one response per accepted write
    typedef struct packed {
        logic                 req_ready;
        logic                 rsp_valid;
        logic [`DMA_ID_W-1:0] rsp_id;
        logic                 rsp_err;
    } term_rsp_t;

endpackage

// ==== dma_legalizer.sv ====
/*
 * Input side of the write termination path. Takes one transfer request at a
 * time and cuts it into word-aligned beats with offset and tailer lanes.
 */

`timescale 1ns/100ps

`include "dma_settings.svh"

module dma_legalizer import dma_xfer_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    input  xfer_req_t xfer_i,
    input  logic      xfer_valid_i,
    output logic      xfer_ready_o,
    output beat_t     beat_o,
    output logic      beat_valid_o,
    input  logic      beat_ready_i
);

    legal_state_e state_q;

    // Current byte address, bytes still to send and the latched id
    addr_t addr_q;
    len_t  remain_q;
    id_t   id_q;

    offs_t offset;
    // Bytes from offset to the end of the current word
    len_t  span;
    logic  is_last;

    // ------------------------------
    // Beat generation
    // ------------------------------
    assign offset  = addr_q[$bits(offs_t)-1:0];
    assign span    = len_t'(`DMA_STRB_W) - len_t'(offset);
    // Final beat once the rest fits into this word
    assign is_last = (remain_q <= span);

    assign xfer_ready_o = (state_q == IDLE);
    assign beat_valid_o = (state_q == BUSY);

    assign beat_o.addr   = addr_t'(addr_q >> $bits(offs_t));
    assign beat_o.id     = id_q;
    assign beat_o.offset = offset;
    // End lane wraps to zero on a word boundary
    assign beat_o.tailer = is_last ? offset + offs_t'(remain_q) : '0;
    assign beat_o.last   = is_last;

    // ------------------------------
    // State and counters
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (xfer_valid_i) begin
                        state_q <= BUSY;
                    end
                end
                BUSY: begin
                    if (beat_ready_i && is_last) begin
                        state_q <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (xfer_valid_i && xfer_ready_o) begin
            addr_q   <= xfer_i.dst_addr;
            remain_q <= xfer_i.length;
            id_q     <= xfer_i.id;
        end else if (beat_valid_o && beat_ready_i) begin
            // Round up to the next word boundary
            addr_q   <= (addr_q | addr_t'(`DMA_STRB_W - 1)) + addr_t'(1);
            remain_q <= remain_q - span;
        end
    end

endmodule

// ==== dma_byte_buffer.sv ====
/*
 * Per-lane byte buffer between the source stream and the init writer.
 * Each lane is its own small FIFO, pushed by strobe and popped by mask.
 */

`timescale 1ns/100ps

`include "dma_settings.svh"

module dma_byte_buffer import dma_bus_pkg::*; (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  data_t                   in_data_i,
    input  strb_t                   in_strb_i,
    input  logic                    in_valid_i,
    output logic                    in_ready_o,
    output byte_t [`DMA_STRB_W-1:0] buf_data_o,
    output strb_t                   buf_valid_o,
    input  strb_t                   buf_pop_i
);

    localparam int unsigned ptr_w = $clog2(`DMA_BUF_DEPTH);
    localparam int unsigned cnt_w = $clog2(`DMA_BUF_DEPTH + 1);

    strb_t lane_full;
    strb_t lane_push;
    // Low in the first cycle out of reset
    logic  run_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    // Stall if any lane this word writes is full
    assign in_ready_o = run_q & ~|(in_strb_i & lane_full);
    assign lane_push  = (in_valid_i && in_ready_o) ? in_strb_i : '0;

    // ------------------------------
    // Lane FIFOs
    // ------------------------------
    for (genvar l = 0; l < `DMA_STRB_W; l++) begin : gen_lane
        byte_t            mem_q [`DMA_BUF_DEPTH];
        logic [ptr_w-1:0] wr_ptr_q;
        logic [ptr_w-1:0] rd_ptr_q;
        logic [cnt_w-1:0] cnt_q;
        logic             pop;

        assign pop = buf_pop_i[l] & (cnt_q != '0);

        // Pointers wrap naturally, depth is a power of two
        always_ff @(posedge clk_i) begin
            if (reset_i) begin
                wr_ptr_q <= '0;
                rd_ptr_q <= '0;
                cnt_q    <= '0;
            end else begin
                if (lane_push[l]) begin
                    wr_ptr_q <= wr_ptr_q + 1'b1;
                end
                if (pop) begin
                    rd_ptr_q <= rd_ptr_q + 1'b1;
                end
                cnt_q <= cnt_q + cnt_w'(lane_push[l]) - cnt_w'(pop);
            end
        end

        always_ff @(posedge clk_i) begin
            if (lane_push[l]) begin
                mem_q[wr_ptr_q] <= in_data_i[l*8 +: 8];
            end
        end

        assign lane_full[l]   = (cnt_q == cnt_w'(`DMA_BUF_DEPTH));
        assign buf_valid_o[l] = (cnt_q != '0);
        // Head of the lane
        assign buf_data_o[l]  = mem_q[rd_ptr_q];
    end

endmodule

// ==== dma_init_write.sv ====
/*
 * Output side of the write termination path. Waits for all lanes of a beat
 * in the buffer, issues one masked word write and turns port responses
 * into beat completions.
 */

`timescale 1ns/100ps

`include "dma_settings.svh"

module dma_init_write import dma_xfer_pkg::*, dma_bus_pkg::*; (
    input  beat_t                   beat_i,
    input  logic                    beat_valid_i,
    output logic                    beat_ready_o,
    input  byte_t [`DMA_STRB_W-1:0] buf_data_i,
    input  strb_t                   buf_valid_i,
    output strb_t                   buf_pop_o,
    output term_req_t               term_req_o,
    input  term_rsp_t               term_rsp_i,
    output done_t                   done_o,
    output logic                    done_valid_o,
    input  logic                    done_ready_i,
    input  logic                    clk_i,
    input  logic                    reset_i
);

    localparam int unsigned ptr_w = $clog2(`DMA_BUF_DEPTH);
    localparam int unsigned cnt_w = $clog2(`DMA_BUF_DEPTH + 1);

    strb_t head_mask;
    strb_t tail_mask;
    // Lanes this beat writes
    strb_t mask_out;
    logic  ready_to_write;
    logic  write_happening;
    data_t data_masked;

    // Last-flag FIFO
    logic             lf_mem_q [`DMA_BUF_DEPTH];
    logic [ptr_w-1:0] lf_wr_q;
    logic [ptr_w-1:0] lf_rd_q;
    logic [cnt_w-1:0] lf_cnt_q;
    logic             lf_full;
    logic             lf_pop;

    // ------------------------------
    // Lane mask
    // ------------------------------
    assign head_mask = '1 << beat_i.offset;
    assign tail_mask = (beat_i.tailer != '0) ? ('1 >> (`DMA_STRB_W - beat_i.tailer)) : '1;
    assign mask_out  = head_mask & tail_mask;

    // Beat present, all its lanes buffered, room to track the response
    assign ready_to_write = beat_valid_i & ((buf_valid_i & mask_out) == mask_out)
        & (buf_valid_i != '0) & ~lf_full;
    assign write_happening = ready_to_write & term_rsp_i.req_ready;

    assign beat_ready_o = write_happening;
    assign buf_pop_o    = write_happening ? mask_out : '0;

    // Zero every byte outside the mask
    always_comb begin
        data_masked = '0;
        for (int i = 0; i < `DMA_STRB_W; i++) begin
            data_masked[i*8 +: 8] = mask_out[i] ? buf_data_i[i] : 8'h00;
        end
    end

    // ------------------------------
    // Port request
    // ------------------------------
    assign term_req_o.req_valid     = ready_to_write;
    assign term_req_o.req_chan.addr = beat_i.addr;
    assign term_req_o.req_chan.id   = beat_i.id;
    assign term_req_o.req_chan.data = ready_to_write ? data_masked : '0;
    assign term_req_o.req_chan.strb = ready_to_write ? mask_out : '0;
    // Response back-pressure comes straight from the host
    assign term_req_o.rsp_ready     = done_ready_i;

    // ------------------------------
    // Responses
    // ------------------------------
    assign lf_full = (lf_cnt_q == cnt_w'(`DMA_BUF_DEPTH));
    assign lf_pop  = term_rsp_i.rsp_valid & done_ready_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            lf_wr_q  <= '0;
            lf_rd_q  <= '0;
            lf_cnt_q <= '0;
        end else begin
            if (write_happening) begin
                lf_wr_q <= lf_wr_q + 1'b1;
            end
            if (lf_pop) begin
                lf_rd_q <= lf_rd_q + 1'b1;
            end
            lf_cnt_q <= lf_cnt_q + cnt_w'(write_happening) - cnt_w'(lf_pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (write_happening) begin
            lf_mem_q[lf_wr_q] <= beat_i.last;
        end
    end

    // Responses come back in write order
    assign done_valid_o = term_rsp_i.rsp_valid;
    assign done_o.id    = term_rsp_i.rsp_id;
    assign done_o.err   = term_rsp_i.rsp_err;
    assign done_o.last  = lf_mem_q[lf_rd_q];

endmodule

// ==== dma_term_top.sv ====
/*
 * Top of the DMA write termination path. Chains the legalizer, the byte
 * buffer and the init writer between the host side and the port.
 */

`timescale 1ns/100ps

`include "dma_settings.svh"

module dma_term_top import dma_xfer_pkg::*, dma_bus_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    // Transfer requests
    input  xfer_req_t xfer_i,
    input  logic      xfer_valid_i,
    output logic      xfer_ready_o,
    // Lane-aligned source stream
    input  data_t     in_data_i,
    input  strb_t     in_strb_i,
    input  logic      in_valid_i,
    output logic      in_ready_o,
    // Termination port
    output term_req_t term_req_o,
    input  term_rsp_t term_rsp_i,
    // Beat completions
    output done_t     done_o,
    output logic      done_valid_o,
    input  logic      done_ready_i
);

    beat_t                   beat;
    logic                    beat_valid;
    logic                    beat_ready;
    byte_t [`DMA_STRB_W-1:0] buf_data;
    strb_t                   buf_valid;
    strb_t                   buf_pop;

    dma_legalizer u_dma_legalizer (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .xfer_i       (xfer_i),
        .xfer_valid_i (xfer_valid_i),
        .xfer_ready_o (xfer_ready_o),
        .beat_o       (beat),
        .beat_valid_o (beat_valid),
        .beat_ready_i (beat_ready)
    );

    dma_byte_buffer u_dma_byte_buffer (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .in_data_i   (in_data_i),
        .in_strb_i   (in_strb_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .buf_data_o  (buf_data),
        .buf_valid_o (buf_valid),
        .buf_pop_i   (buf_pop)
    );

    dma_init_write u_dma_init_write (
        .beat_i       (beat),
        .beat_valid_i (beat_valid),
        .beat_ready_o (beat_ready),
        .buf_data_i   (buf_data),
        .buf_valid_i  (buf_valid),
        .buf_pop_o    (buf_pop),
        .term_req_o   (term_req_o),
        .term_rsp_i   (term_rsp_i),
        .done_o       (done_o),
        .done_valid_o (done_valid_o),
        .done_ready_i (done_ready_i),
        .clk_i        (clk_i),
        .reset_i      (reset_i)
    );

endmodule

// ==== dma_term_checker.sv ====
/*
 * Protocol and masking assertions for the DMA write termination top.
 * Bound into dma_term_top from the end of this file.
 */

`timescale 1ns/100ps

`include "dma_settings.svh"

module dma_term_checker import dma_xfer_pkg::*, dma_bus_pkg::*; (
    input logic      clk_i,
    input logic      reset_i,
    input term_req_t term_req_i,
    input term_rsp_t term_rsp_i,
    input done_t     done_i,
    input logic      done_valid_i,
    input logic      done_ready_i,
    input logic      in_ready_i,
    input strb_t     buf_valid_i
);

    // Number of failed assertions so far
    int unsigned fail_cnt = 0;

    // Strobe widened to one mask bit per data bit
    data_t byte_mask;

    always_comb begin
        for (int i = 0; i < `DMA_STRB_W; i++) begin
            byte_mask[i*8 +: 8] = {8{term_req_i.req_chan.strb[i]}};
        end
    end

    // ------------------------------
    // Write channel
    // ------------------------------
    // Bytes outside the strobe are zero
    a_zero_outside: assert property (@(posedge clk_i) disable iff (reset_i)
        term_req_i.req_valid |-> ((term_req_i.req_chan.data & ~byte_mask) == '0))
        else begin
            fail_cnt++;
            $error("write data has nonzero bytes outside strb");
        end

    // A write always carries at least one lane
    a_strb_nonzero: assert property (@(posedge clk_i) disable iff (reset_i)
        term_req_i.req_valid |-> (term_req_i.req_chan.strb != '0))
        else begin
            fail_cnt++;
            $error("write issued with an empty strb");
        end

    // Stalled write keeps valid and payload
    a_req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        term_req_i.req_valid && !term_rsp_i.req_ready
        |=> term_req_i.req_valid && $stable(term_req_i.req_chan))
        else begin
            fail_cnt++;
            $error("write payload changed while req_ready was low");
        end

    // Masked lanes stay buffered during the stall
    a_buf_held: assert property (@(posedge clk_i) disable iff (reset_i)
        term_req_i.req_valid && !term_rsp_i.req_ready
        |=> ((buf_valid_i & $past(term_req_i.req_chan.strb)) == $past(term_req_i.req_chan.strb)))
        else begin
            fail_cnt++;
            $error("buffered lanes of a stalled write went away");
        end

    // ------------------------------
    // Completions and reset
    // ------------------------------
    a_done_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        done_valid_i && !done_ready_i |=> done_valid_i && $stable(done_i))
        else begin
            fail_cnt++;
            $error("completion changed while done_ready_i was low");
        end

    // First cycle out of reset is quiet
    a_reset_quiet: assert property (@(posedge clk_i)
        $fell(reset_i) |-> !term_req_i.req_valid && !done_valid_i && !in_ready_i)
        else begin
            fail_cnt++;
            $error("handshake outputs high in the first cycle after reset");
        end

endmodule

bind dma_term_top dma_term_checker u_dma_term_checker (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .term_req_i   (term_req_o),
    .term_rsp_i   (term_rsp_i),
    .done_i       (done_o),
    .done_valid_i (done_valid_o),
    .done_ready_i (done_ready_i),
    .in_ready_i   (in_ready_o),
    .buf_valid_i  (buf_valid)
);

// ==== dma_term_tb.sv ====
/*
 * Testbench for the DMA write termination top. Sends random transfers with
 * a matching lane-aligned byte stream, models the port target and scores
 * every write and completion against the transfer rules.
 */

`timescale 1ns/100ps

`include "dma_settings.svh"

module dma_term_tb import dma_xfer_pkg::*, dma_bus_pkg::*; ();

    localparam int timeout_cycles = 500;
    localparam int num_xfers      = 40;
    localparam int lanes          = `DMA_STRB_W;

    logic      clk;
    logic      reset;
    xfer_req_t xfer;
    logic      xfer_valid;
    logic      xfer_ready;
    data_t     in_data;
    strb_t     in_strb;
    logic      in_valid;
    logic      in_ready;
    term_req_t term_req;
    term_rsp_t term_rsp;
    done_t     done;
    logic      done_valid;
    logic      done_ready;

    // Separate generators for requests and for the target side
    logic [31:0] rng_req;
    logic [31:0] rng_tgt;
    int          errors;
    int          checks;
    // Strobe bits and completions seen for the current transfer
    int          strb_total;
    int          done_total;
    // Completions with the last flag set in the current transfer
    int          last_total;

    // Expected writes and completions, in port order
    addr_t exp_addr_q [$];
    strb_t exp_strb_q [$];
    data_t exp_data_q [$];
    done_t exp_done_q [$];
    // Ids of accepted writes still owed a response
    id_t   rsp_q [$];
    // Source words of the current transfer
    data_t stream_data_q [$];
    strb_t stream_strb_q [$];

    dma_term_top u_dma_term_top (
        .clk_i        (clk),
        .reset_i      (reset),
        .xfer_i       (xfer),
        .xfer_valid_i (xfer_valid),
        .xfer_ready_o (xfer_ready),
        .in_data_i    (in_data),
        .in_strb_i    (in_strb),
        .in_valid_i   (in_valid),
        .in_ready_o   (in_ready),
        .term_req_o   (term_req),
        .term_rsp_i   (term_rsp),
        .done_o       (done),
        .done_valid_o (done_valid),
        .done_ready_i (done_ready)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Checks %0d, errors %0d", checks, errors);
        $display("Result: FAILED");
        $finish;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // ------------------------------
    // Port target and scoreboard
    // ------------------------------
    task automatic check_write();
        if (exp_addr_q.size() == 0) begin
            errors++;
            $display("Unexpected write at %0t to word %h", $time, term_req.req_chan.addr);
        end else begin
            check_value("req_chan.addr", term_req.req_chan.addr, exp_addr_q.pop_front());
            check_value("req_chan.strb", term_req.req_chan.strb, exp_strb_q.pop_front());
            check_value("req_chan.data", term_req.req_chan.data, exp_data_q.pop_front());
            strb_total += $countones(term_req.req_chan.strb);
        end
    endtask

    task automatic check_done();
        // Every accepted completion counts, expected or not
        done_total++;
        if (done.last) begin
            last_total++;
        end
        if (exp_done_q.size() == 0) begin
            errors++;
            $display("Unexpected completion at %0t with id %0d", $time, done.id);
        end else begin
            check_value("done_o.id", done.id, exp_done_q[0].id);
            check_value("done_o.last", done.last, exp_done_q[0].last);
            check_value("done_o.err", done.err, 1'b0);
            void'(exp_done_q.pop_front());
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            rsp_q.delete();
        end else begin
            if (term_req.req_valid && term_rsp.req_ready) begin
                rsp_q.push_back(term_req.req_chan.id);
                check_write();
            end
            // Response handshake on the port itself
            if (term_rsp.rsp_valid && term_req.rsp_ready) begin
                void'(rsp_q.pop_front());
            end
            if (done_valid && done_ready) begin
                check_done();
            end
        end
    end

    // Responses in order, random back-pressure on both sides
    always @(negedge clk) begin
        rng_tgt = xorshift32(rng_tgt);
        term_rsp.req_ready = rng_tgt[0] | rng_tgt[1];
        term_rsp.rsp_valid = (rsp_q.size() > 0);
        term_rsp.rsp_id    = (rsp_q.size() > 0) ? rsp_q[0] : '0;
        term_rsp.rsp_err   = 1'b0;
        done_ready         = rng_tgt[2] | rng_tgt[3];
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    task automatic send_request(input xfer_req_t req);
        int cycles;
        @(negedge clk);
        xfer       = req;
        xfer_valid = 1'b1;
        cycles     = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!xfer_ready && cycles < timeout_cycles);
        if (!xfer_ready) begin
            abort_run("Timeout: transfer request was never accepted");
        end
        @(negedge clk);
        xfer_valid = 1'b0;
    endtask

    // One source word per cycle while in_ready_o allows
    task automatic feed_stream();
        int cycles;
        while (stream_data_q.size() > 0) begin
            @(negedge clk);
            in_data  = stream_data_q.pop_front();
            in_strb  = stream_strb_q.pop_front();
            in_valid = 1'b1;
            cycles   = 0;
            do begin
                @(posedge clk);
                cycles++;
            end while (!in_ready && cycles < timeout_cycles);
            if (!in_ready) begin
                abort_run("Timeout: source stream word was never accepted");
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic run_xfer(input addr_t addr, input int len, input id_t id);
        int        base;
        int        first_w;
        int        last_w;
        int        w;
        int        l;
        int        a;
        int        cycles;
        strb_t     strb;
        data_t     data;
        addr_t     waddr;
        done_t     dn;
        xfer_req_t req;
        base       = addr;
        first_w    = base / lanes;
        last_w     = (base + len - 1) / lanes;
        strb_total = 0;
        done_total = 0;
        last_total = 0;
        // Byte at address A carries (A mod 256) xor id in lane A mod 4
        for (w = first_w; w <= last_w; w++) begin
            strb = '0;
            data = '0;
            for (l = 0; l < lanes; l++) begin
                a = w * lanes + l;
                if (a >= base && a < base + len) begin
                    strb[l]        = 1'b1;
                    data[l*8 +: 8] = a[7:0] ^ 8'(id);
                end
            end
            waddr = w;
            exp_addr_q.push_back(waddr);
            exp_strb_q.push_back(strb);
            exp_data_q.push_back(data);
            stream_data_q.push_back(data);
            stream_strb_q.push_back(strb);
            dn.id   = id;
            dn.err  = 1'b0;
            dn.last = (w == last_w);
            exp_done_q.push_back(dn);
        end
        req.dst_addr = addr;
        req.length   = len;
        req.id       = id;
        fork
            send_request(req);
            feed_stream();
        join
        // Transfer ends on the completion that the DUT marks as last
        cycles = 0;
        while (last_total == 0 && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (last_total == 0) begin
            abort_run("Timeout: final completion of a transfer never arrived");
        end
        check_value("strobe bit total", strb_total, len);
        check_value("completion count", done_total, last_w - first_w + 1);
    endtask

    initial begin : main_seq
        int    i;
        int    chk_fails;
        int    len;
        addr_t addr;
        id_t   id;
        clk        = 1'b0;
        reset      = 1'b1;
        xfer       = '0;
        xfer_valid = 1'b0;
        in_data    = '0;
        in_strb    = '0;
        in_valid   = 1'b0;
        term_rsp   = '0;
        done_ready = 1'b0;
        errors     = 0;
        checks     = 0;
        rng_req    = 32'h9d208d86;
        rng_tgt    = ~32'h9d208d86;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        for (i = 0; i < num_xfers; i++) begin
            rng_req = xorshift32(rng_req);
            addr    = addr_t'(rng_req[11:0]);
            len     = 1 + rng_req[20:16];
            id      = rng_req[14:12];
            run_xfer(addr, len, id);
        end
        repeat (4) @(negedge clk);
        chk_fails = u_dma_term_top.u_dma_term_checker.fail_cnt;
        $display("Checks %0d, errors %0d, assertion failures %0d", checks, errors, chk_fails);
        if (errors == 0 && chk_fails == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+.
dma_xfer_pkg.sv
dma_bus_pkg.sv
dma_legalizer.sv
dma_byte_buffer.sv
dma_init_write.sv
dma_term_top.sv
dma_term_checker.sv
dma_term_tb.sv
